// File: rtl/axi_tcdm_pkg.sv
/*
  Shared widths, vector types and the bridge FSM encoding for the
  AXI to TCDM subsystem. Modules refer to these by scoped name
*/
package axi_tcdm_pkg;

  localparam int unsigned AXI_DATA_WIDTH  = 64;
  localparam int unsigned TCDM_DATA_WIDTH = 32;
  // one TCDM lane per 32-bit slice of the AXI beat
  localparam int unsigned NB_LANES        = AXI_DATA_WIDTH / TCDM_DATA_WIDTH;

  typedef logic [31:0]                    axi_addr_t;
  typedef logic [3:0]                     axi_id_t;
  typedef logic [7:0]                     axi_len_t;
  typedef logic [AXI_DATA_WIDTH-1:0]      axi_data_t;
  typedef logic [AXI_DATA_WIDTH/8-1:0]    axi_strb_t;
  typedef logic [1:0]                     axi_resp_t;

  typedef logic [31:0]                    tcdm_addr_t;
  typedef logic [TCDM_DATA_WIDTH-1:0]     tcdm_data_t;
  typedef logic [TCDM_DATA_WIDTH/8-1:0]   tcdm_be_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  typedef enum logic [2:0] {
    IDLE,
    WR_DATA,
    WR_REQ,
    WR_RESP,
    RD_REQ,
    RD_WAIT,
    RD_DATA
  } bridge_state_e;

endpackage

// File: rtl/tcdm_if.sv
/*
  TCDM request/response bundle. The master holds req and its fields
  until gnt, and read data returns one cycle after the grant
*/
`timescale 1ns/100ps

interface tcdm_if;

  logic                       req;
  axi_tcdm_pkg::tcdm_addr_t   add;
  // high for a read
  logic                       wen;
  axi_tcdm_pkg::tcdm_data_t   data;
  axi_tcdm_pkg::tcdm_be_t     be;
  logic                       gnt;
  logic                       r_valid;
  axi_tcdm_pkg::tcdm_data_t   r_data;

  modport master (
    output req, add, wen, data, be,
    input  gnt, r_valid, r_data
  );

  modport slave (
    input  req, add, wen, data, be,
    output gnt, r_valid, r_data
  );

endinterface

// File: rtl/axi2mem.sv
/*
  AXI4 slave to TCDM bridge. Handles one INCR burst at a time and splits
  every 64-bit beat into per-lane 32-bit TCDM accesses. Read words are
  gathered from the lanes and returned as one R beat
*/
`timescale 1ns/100ps

module axi2mem #(
  parameter int unsigned NB_LANES = axi_tcdm_pkg::NB_LANES
) (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic                                          aw_valid_i,
  input  axi_tcdm_pkg::axi_addr_t                       aw_addr_i,
  input  axi_tcdm_pkg::axi_len_t                        aw_len_i,
  input  axi_tcdm_pkg::axi_id_t                         aw_id_i,
  output logic                                          aw_ready_o,
  input  logic                                          ar_valid_i,
  input  axi_tcdm_pkg::axi_addr_t                       ar_addr_i,
  input  axi_tcdm_pkg::axi_len_t                        ar_len_i,
  input  axi_tcdm_pkg::axi_id_t                         ar_id_i,
  output logic                                          ar_ready_o,
  input  logic                                          w_valid_i,
  input  axi_tcdm_pkg::axi_data_t                       w_data_i,
  input  axi_tcdm_pkg::axi_strb_t                       w_strb_i,
  input  logic                                          w_last_i,
  output logic                                          w_ready_o,
  output logic                                          r_valid_o,
  output axi_tcdm_pkg::axi_data_t                       r_data_o,
  output axi_tcdm_pkg::axi_resp_t                       r_resp_o,
  output logic                                          r_last_o,
  output axi_tcdm_pkg::axi_id_t                         r_id_o,
  input  logic                                          r_ready_i,
  output logic                                          b_valid_o,
  output axi_tcdm_pkg::axi_resp_t                       b_resp_o,
  output axi_tcdm_pkg::axi_id_t                         b_id_o,
  input  logic                                          b_ready_i,
  output logic                 [NB_LANES-1:0]           tcdm_req_o,
  output axi_tcdm_pkg::tcdm_addr_t [NB_LANES-1:0]       tcdm_add_o,
  output logic                 [NB_LANES-1:0]           tcdm_type_o,
  output axi_tcdm_pkg::tcdm_data_t [NB_LANES-1:0]       tcdm_data_o,
  output axi_tcdm_pkg::tcdm_be_t   [NB_LANES-1:0]       tcdm_be_o,
  input  logic                 [NB_LANES-1:0]           tcdm_gnt_i,
  input  logic                 [NB_LANES-1:0]           tcdm_r_valid_i,
  input  axi_tcdm_pkg::tcdm_data_t [NB_LANES-1:0]       tcdm_r_data_i,
  output logic                                          busy_o
);

  localparam int unsigned BEAT_BYTES = axi_tcdm_pkg::AXI_DATA_WIDTH / 8;
  localparam int unsigned LANE_BITS  = axi_tcdm_pkg::TCDM_DATA_WIDTH;
  localparam int unsigned LANE_BYTES = LANE_BITS / 8;

  axi_tcdm_pkg::bridge_state_e state_q;
  axi_tcdm_pkg::axi_addr_t     addr_q;
  axi_tcdm_pkg::axi_id_t       id_q;
  axi_tcdm_pkg::axi_len_t      len_q;
  axi_tcdm_pkg::axi_len_t      cnt_q;
  axi_tcdm_pkg::axi_data_t     wdata_q;
  axi_tcdm_pkg::axi_strb_t     wstrb_q;
  logic                        wlast_q;
  logic [NB_LANES-1:0]         pend_q;
  logic [NB_LANES-1:0]         pend_left;
  logic                        last_beat;

  // lanes still waiting for a grant after this cycle
  assign pend_left = pend_q & ~tcdm_gnt_i;
  assign last_beat = (cnt_q == len_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= axi_tcdm_pkg::IDLE;
      addr_q  <= '0;
      id_q    <= '0;
      len_q   <= '0;
      cnt_q   <= '0;
      wlast_q <= 1'b0;
      pend_q  <= '0;
    end else begin
      unique case (state_q)
        axi_tcdm_pkg::IDLE: begin
          // AW takes priority when both address channels are valid
          if (aw_valid_i) begin
            addr_q  <= aw_addr_i;
            id_q    <= aw_id_i;
            len_q   <= aw_len_i;
            cnt_q   <= '0;
            state_q <= axi_tcdm_pkg::WR_DATA;
          end else if (ar_valid_i) begin
            addr_q  <= ar_addr_i;
            id_q    <= ar_id_i;
            len_q   <= ar_len_i;
            cnt_q   <= '0;
            pend_q  <= '1;
            state_q <= axi_tcdm_pkg::RD_REQ;
          end
        end
        axi_tcdm_pkg::WR_DATA: begin
          if (w_valid_i) begin
            wlast_q <= w_last_i;
            // a lane with no enabled byte skips the TCDM entirely
            for (int k = 0; k < NB_LANES; k++) begin
              pend_q[k] <= |w_strb_i[k*LANE_BYTES +: LANE_BYTES];
            end
            state_q <= axi_tcdm_pkg::WR_REQ;
          end
        end
        axi_tcdm_pkg::WR_REQ: begin
          pend_q <= pend_left;
          if (pend_left == '0) begin
            if (wlast_q || last_beat) begin
              state_q <= axi_tcdm_pkg::WR_RESP;
            end else begin
              cnt_q   <= cnt_q + 8'd1;
              addr_q  <= addr_q + BEAT_BYTES;
              state_q <= axi_tcdm_pkg::WR_DATA;
            end
          end
        end
        axi_tcdm_pkg::WR_RESP: begin
          if (b_ready_i) begin
            state_q <= axi_tcdm_pkg::IDLE;
          end
        end
        axi_tcdm_pkg::RD_REQ: begin
          pend_q <= pend_left;
          if (pend_left == '0) begin
            state_q <= axi_tcdm_pkg::RD_WAIT;
          end
        end
        axi_tcdm_pkg::RD_WAIT: begin
          // the wrap keeps each lane's word, so they may arrive apart
          if (&tcdm_r_valid_i) begin
            state_q <= axi_tcdm_pkg::RD_DATA;
          end
        end
        axi_tcdm_pkg::RD_DATA: begin
          if (r_ready_i) begin
            if (last_beat) begin
              state_q <= axi_tcdm_pkg::IDLE;
            end else begin
              cnt_q   <= cnt_q + 8'd1;
              addr_q  <= addr_q + BEAT_BYTES;
              pend_q  <= '1;
              state_q <= axi_tcdm_pkg::RD_REQ;
            end
          end
        end
        default: state_q <= axi_tcdm_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == axi_tcdm_pkg::WR_DATA && w_valid_i) begin
      wdata_q <= w_data_i;
      wstrb_q <= w_strb_i;
    end
  end

  assign aw_ready_o = (state_q == axi_tcdm_pkg::IDLE);
  assign ar_ready_o = (state_q == axi_tcdm_pkg::IDLE) && !aw_valid_i;
  assign w_ready_o  = (state_q == axi_tcdm_pkg::WR_DATA);
  assign b_valid_o  = (state_q == axi_tcdm_pkg::WR_RESP);
  assign b_resp_o   = axi_tcdm_pkg::RESP_OKAY;
  assign b_id_o     = id_q;
  assign r_valid_o  = (state_q == axi_tcdm_pkg::RD_DATA);
  assign r_resp_o   = axi_tcdm_pkg::RESP_OKAY;
  assign r_last_o   = last_beat;
  assign r_id_o     = id_q;
  assign busy_o     = (state_q != axi_tcdm_pkg::IDLE);
  assign tcdm_req_o = pend_q;

  for (genvar k = 0; k < NB_LANES; k++) begin : gen_lane
    assign tcdm_add_o[k]  = addr_q + k * LANE_BYTES;
    assign tcdm_type_o[k] = (state_q == axi_tcdm_pkg::RD_REQ);
    assign tcdm_data_o[k] = wdata_q[k*LANE_BITS +: LANE_BITS];
    assign tcdm_be_o[k]   = wstrb_q[k*LANE_BYTES +: LANE_BYTES];
    assign r_data_o[k*LANE_BITS +: LANE_BITS] = tcdm_r_data_i[k];
  end

  // the beat stays on R, data included, for as long as the master stalls
  r_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o));

endmodule

// File: rtl/axi2mem_wrap.sv
/*
  Wraps the AXI to TCDM bridge and binds its lane vectors to one TCDM
  master port per lane. Each lane's read word is kept here until the
  lane issues its next request
*/
`timescale 1ns/100ps

module axi2mem_wrap #(
  parameter int unsigned NB_LANES = axi_tcdm_pkg::NB_LANES
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      axi_slave_aw_valid_i,
  input  axi_tcdm_pkg::axi_addr_t   axi_slave_aw_addr_i,
  input  axi_tcdm_pkg::axi_len_t    axi_slave_aw_len_i,
  input  axi_tcdm_pkg::axi_id_t     axi_slave_aw_id_i,
  output logic                      axi_slave_aw_ready_o,
  input  logic                      axi_slave_ar_valid_i,
  input  axi_tcdm_pkg::axi_addr_t   axi_slave_ar_addr_i,
  input  axi_tcdm_pkg::axi_len_t    axi_slave_ar_len_i,
  input  axi_tcdm_pkg::axi_id_t     axi_slave_ar_id_i,
  output logic                      axi_slave_ar_ready_o,
  input  logic                      axi_slave_w_valid_i,
  input  axi_tcdm_pkg::axi_data_t   axi_slave_w_data_i,
  input  axi_tcdm_pkg::axi_strb_t   axi_slave_w_strb_i,
  input  logic                      axi_slave_w_last_i,
  output logic                      axi_slave_w_ready_o,
  output logic                      axi_slave_r_valid_o,
  output axi_tcdm_pkg::axi_data_t   axi_slave_r_data_o,
  output axi_tcdm_pkg::axi_resp_t   axi_slave_r_resp_o,
  output logic                      axi_slave_r_last_o,
  output axi_tcdm_pkg::axi_id_t     axi_slave_r_id_o,
  input  logic                      axi_slave_r_ready_i,
  output logic                      axi_slave_b_valid_o,
  output axi_tcdm_pkg::axi_resp_t   axi_slave_b_resp_o,
  output axi_tcdm_pkg::axi_id_t     axi_slave_b_id_o,
  input  logic                      axi_slave_b_ready_i,
  tcdm_if.master                    tcdm_master [NB_LANES],
  output logic                      busy_o
);

  logic [NB_LANES-1:0]                        lane_req;
  logic [NB_LANES-1:0]                        lane_wen;
  logic [NB_LANES-1:0]                        lane_gnt;
  logic [NB_LANES-1:0]                        hold_valid_q;
  axi_tcdm_pkg::tcdm_addr_t [NB_LANES-1:0]    lane_add;
  axi_tcdm_pkg::tcdm_data_t [NB_LANES-1:0]    lane_wdata;
  axi_tcdm_pkg::tcdm_be_t   [NB_LANES-1:0]    lane_be;
  axi_tcdm_pkg::tcdm_data_t [NB_LANES-1:0]    hold_data_q;

  for (genvar k = 0; k < NB_LANES; k++) begin : gen_bind
    assign tcdm_master[k].req  = lane_req[k];
    assign tcdm_master[k].add  = lane_add[k];
    assign tcdm_master[k].wen  = lane_wen[k];
    assign tcdm_master[k].data = lane_wdata[k];
    assign tcdm_master[k].be   = lane_be[k];
    assign lane_gnt[k]         = tcdm_master[k].gnt;

    // a new grant on this lane starts the next beat, so the old word goes
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        hold_valid_q[k] <= 1'b0;
      end else if (tcdm_master[k].r_valid) begin
        hold_valid_q[k] <= 1'b1;
      end else if (lane_req[k] && lane_gnt[k]) begin
        hold_valid_q[k] <= 1'b0;
      end
    end

    always_ff @(posedge clk_i) begin
      if (tcdm_master[k].r_valid) begin
        hold_data_q[k] <= tcdm_master[k].r_data;
      end
    end
  end

  axi2mem #(
    .NB_LANES       ( NB_LANES             )
  ) i_axi2mem (
    .clk_i          ( clk_i                ),
    .arst_n_i       ( arst_n_i             ),
    .aw_valid_i     ( axi_slave_aw_valid_i ),
    .aw_addr_i      ( axi_slave_aw_addr_i  ),
    .aw_len_i       ( axi_slave_aw_len_i   ),
    .aw_id_i        ( axi_slave_aw_id_i    ),
    .aw_ready_o     ( axi_slave_aw_ready_o ),
    .ar_valid_i     ( axi_slave_ar_valid_i ),
    .ar_addr_i      ( axi_slave_ar_addr_i  ),
    .ar_len_i       ( axi_slave_ar_len_i   ),
    .ar_id_i        ( axi_slave_ar_id_i    ),
    .ar_ready_o     ( axi_slave_ar_ready_o ),
    .w_valid_i      ( axi_slave_w_valid_i  ),
    .w_data_i       ( axi_slave_w_data_i   ),
    .w_strb_i       ( axi_slave_w_strb_i   ),
    .w_last_i       ( axi_slave_w_last_i   ),
    .w_ready_o      ( axi_slave_w_ready_o  ),
    .r_valid_o      ( axi_slave_r_valid_o  ),
    .r_data_o       ( axi_slave_r_data_o   ),
    .r_resp_o       ( axi_slave_r_resp_o   ),
    .r_last_o       ( axi_slave_r_last_o   ),
    .r_id_o         ( axi_slave_r_id_o     ),
    .r_ready_i      ( axi_slave_r_ready_i  ),
    .b_valid_o      ( axi_slave_b_valid_o  ),
    .b_resp_o       ( axi_slave_b_resp_o   ),
    .b_id_o         ( axi_slave_b_id_o     ),
    .b_ready_i      ( axi_slave_b_ready_i  ),
    .tcdm_req_o     ( lane_req             ),
    .tcdm_add_o     ( lane_add             ),
    .tcdm_type_o    ( lane_wen             ),
    .tcdm_data_o    ( lane_wdata           ),
    .tcdm_be_o      ( lane_be              ),
    .tcdm_gnt_i     ( lane_gnt             ),
    .tcdm_r_valid_i ( hold_valid_q         ),
    .tcdm_r_data_i  ( hold_data_q          ),
    .busy_o         ( busy_o               )
  );

endmodule

// File: rtl/tcdm_rr_arbiter.sv
/*
  Round-robin arbiter that puts the lane masters onto the single memory
  port. The grant is combinational; read data is steered back to the
  lane that was granted one cycle earlier
*/
`timescale 1ns/100ps

module tcdm_rr_arbiter #(
  parameter int unsigned NB_LANES  = axi_tcdm_pkg::NB_LANES,
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic    clk_i,
  input  logic    arst_n_i,
  tcdm_if.slave   lane_s [NB_LANES],
  tcdm_if.master  mem_m
);

  localparam int unsigned LANE_W = (NB_LANES > 1) ? $clog2(NB_LANES) : 1;
  localparam int unsigned IDX_W  = $clog2(MEM_WORDS);

  logic [NB_LANES-1:0]        lane_req;
  logic [NB_LANES-1:0]        lane_wen;
  logic [NB_LANES-1:0]        grant;
  axi_tcdm_pkg::tcdm_addr_t   lane_add  [NB_LANES];
  axi_tcdm_pkg::tcdm_data_t   lane_data [NB_LANES];
  axi_tcdm_pkg::tcdm_be_t     lane_be   [NB_LANES];
  logic [LANE_W-1:0]          ptr_q;
  logic [LANE_W-1:0]          rsel_q;
  logic [LANE_W-1:0]          sel;
  logic                       found;

  for (genvar k = 0; k < NB_LANES; k++) begin : gen_lane
    assign lane_req[k]       = lane_s[k].req;
    assign lane_wen[k]       = lane_s[k].wen;
    assign lane_add[k]       = lane_s[k].add;
    assign lane_data[k]      = lane_s[k].data;
    assign lane_be[k]        = lane_s[k].be;
    assign lane_s[k].gnt     = grant[k];
    assign lane_s[k].r_valid = mem_m.r_valid && (rsel_q == LANE_W'(k));
    assign lane_s[k].r_data  = mem_m.r_data;
  end

  // search starts at the lane after the previous winner
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    sel   = '0;
    for (int unsigned i = 0; i < NB_LANES; i++) begin
      idx = (ptr_q + i) % NB_LANES;
      if (!found && lane_req[idx]) begin
        found = 1'b1;
        sel   = LANE_W'(idx);
      end
    end
  end

  assign grant = (found && mem_m.gnt) ? (NB_LANES'(1) << sel) : '0;

  assign mem_m.req  = found;
  // byte address to word index inside the memory
  assign mem_m.add  = axi_tcdm_pkg::tcdm_addr_t'(lane_add[sel][IDX_W+1:2]);
  assign mem_m.wen  = lane_wen[sel];
  assign mem_m.data = lane_data[sel];
  assign mem_m.be   = lane_be[sel];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q  <= '0;
      rsel_q <= '0;
    end else if (found && mem_m.gnt) begin
      ptr_q  <= (sel == LANE_W'(NB_LANES - 1)) ? '0 : sel + 1'b1;
      rsel_q <= sel;
    end
  end

  // the steering register only points at the right lane if read data
  // follows a read grant by exactly one cycle
  rdata_latency_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_m.r_valid |-> $past(mem_m.req && mem_m.gnt && mem_m.wen));

endmodule

// File: rtl/tcdm_sram.sv
/*
  Single-port word memory on a TCDM slave port. Always grants, writes
  the enabled bytes and returns read data one cycle after the request
*/
`timescale 1ns/100ps

module tcdm_sram #(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic   clk_i,
  tcdm_if.slave  mem_s
);

  localparam int unsigned IDX_W  = $clog2(MEM_WORDS);
  localparam int unsigned NB_BYTES = $bits(axi_tcdm_pkg::tcdm_be_t);

  axi_tcdm_pkg::tcdm_data_t mem_q [MEM_WORDS];
  logic [IDX_W-1:0]         idx;

  assign idx       = mem_s.add[IDX_W-1:0];
  assign mem_s.gnt = 1'b1;

  always_ff @(posedge clk_i) begin
    if (mem_s.req && !mem_s.wen) begin
      for (int b = 0; b < NB_BYTES; b++) begin
        if (mem_s.be[b]) begin
          mem_q[idx][b*8 +: 8] <= mem_s.data[b*8 +: 8];
        end
      end
    end
    if (mem_s.req && mem_s.wen) begin
      mem_s.r_data <= mem_q[idx];
    end
    mem_s.r_valid <= mem_s.req && mem_s.wen;
  end

  // upstream address bits must stay inside the array
  addr_range_a: assert property (@(posedge clk_i) mem_s.req |-> mem_s.add < MEM_WORDS);

endmodule

// File: rtl/tcdm_subsys_top.sv
/*
  Subsystem top level. An AXI4 slave on plain ports feeds the bridge
  wrap, whose lanes share one SRAM through a round-robin arbiter
*/
`timescale 1ns/100ps

module tcdm_subsys_top #(
  parameter int unsigned MEM_WORDS = 1024,
  parameter int unsigned NB_LANES  = axi_tcdm_pkg::NB_LANES
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      aw_valid_i,
  input  axi_tcdm_pkg::axi_addr_t   aw_addr_i,
  input  axi_tcdm_pkg::axi_len_t    aw_len_i,
  input  axi_tcdm_pkg::axi_id_t     aw_id_i,
  output logic                      aw_ready_o,
  input  logic                      ar_valid_i,
  input  axi_tcdm_pkg::axi_addr_t   ar_addr_i,
  input  axi_tcdm_pkg::axi_len_t    ar_len_i,
  input  axi_tcdm_pkg::axi_id_t     ar_id_i,
  output logic                      ar_ready_o,
  input  logic                      w_valid_i,
  input  axi_tcdm_pkg::axi_data_t   w_data_i,
  input  axi_tcdm_pkg::axi_strb_t   w_strb_i,
  input  logic                      w_last_i,
  output logic                      w_ready_o,
  output logic                      r_valid_o,
  output axi_tcdm_pkg::axi_data_t   r_data_o,
  output axi_tcdm_pkg::axi_resp_t   r_resp_o,
  output logic                      r_last_o,
  output axi_tcdm_pkg::axi_id_t     r_id_o,
  input  logic                      r_ready_i,
  output logic                      b_valid_o,
  output axi_tcdm_pkg::axi_resp_t   b_resp_o,
  output axi_tcdm_pkg::axi_id_t     b_id_o,
  input  logic                      b_ready_i,
  output logic                      busy_o
);

  tcdm_if lane_bus [NB_LANES] ();
  tcdm_if mem_bus ();

  axi2mem_wrap #(
    .NB_LANES             ( NB_LANES   )
  ) i_axi2mem_wrap (
    .clk_i                ( clk_i      ),
    .arst_n_i             ( arst_n_i   ),
    .axi_slave_aw_valid_i ( aw_valid_i ),
    .axi_slave_aw_addr_i  ( aw_addr_i  ),
    .axi_slave_aw_len_i   ( aw_len_i   ),
    .axi_slave_aw_id_i    ( aw_id_i    ),
    .axi_slave_aw_ready_o ( aw_ready_o ),
    .axi_slave_ar_valid_i ( ar_valid_i ),
    .axi_slave_ar_addr_i  ( ar_addr_i  ),
    .axi_slave_ar_len_i   ( ar_len_i   ),
    .axi_slave_ar_id_i    ( ar_id_i    ),
    .axi_slave_ar_ready_o ( ar_ready_o ),
    .axi_slave_w_valid_i  ( w_valid_i  ),
    .axi_slave_w_data_i   ( w_data_i   ),
    .axi_slave_w_strb_i   ( w_strb_i   ),
    .axi_slave_w_last_i   ( w_last_i   ),
    .axi_slave_w_ready_o  ( w_ready_o  ),
    .axi_slave_r_valid_o  ( r_valid_o  ),
    .axi_slave_r_data_o   ( r_data_o   ),
    .axi_slave_r_resp_o   ( r_resp_o   ),
    .axi_slave_r_last_o   ( r_last_o   ),
    .axi_slave_r_id_o     ( r_id_o     ),
    .axi_slave_r_ready_i  ( r_ready_i  ),
    .axi_slave_b_valid_o  ( b_valid_o  ),
    .axi_slave_b_resp_o   ( b_resp_o   ),
    .axi_slave_b_id_o     ( b_id_o     ),
    .axi_slave_b_ready_i  ( b_ready_i  ),
    .tcdm_master          ( lane_bus   ),
    .busy_o               ( busy_o     )
  );

  tcdm_rr_arbiter #(
    .NB_LANES  ( NB_LANES  ),
    .MEM_WORDS ( MEM_WORDS )
  ) i_tcdm_rr_arbiter (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .lane_s    ( lane_bus  ),
    .mem_m     ( mem_bus   )
  );

  tcdm_sram #(
    .MEM_WORDS ( MEM_WORDS )
  ) i_tcdm_sram (
    .clk_i     ( clk_i     ),
    .mem_s     ( mem_bus   )
  );

endmodule

// File: testbench/tb_tcdm_subsys.sv
/*
  Random-stimulus testbench for the AXI to TCDM subsystem. A byte-wide
  reference memory models the SRAM, and every R and B response is checked
  against it. Run through flist.f with tb_tcdm_subsys as the top module
*/
`timescale 1ns/100ps

module tb_tcdm_subsys;

  localparam int CLK_PERIOD  = 100;
  localparam int MEM_WORDS   = 256;
  localparam int MEM_BYTES   = MEM_WORDS * 4;
  localparam int MEM_BEATS   = MEM_BYTES / 8;
  localparam int NUM_FILL    = MEM_BEATS / 16;
  localparam int NUM_RAND    = 40;
  // fill writes, final readback and up to two bursts per random step
  localparam int NUM_TXN     = 2 * NUM_FILL + 2 * NUM_RAND;
  localparam int WDOG_CYCLES = NUM_TXN * 200;

  logic                      clk_i;
  logic                      arst_n_i;
  logic                      aw_valid_i;
  axi_tcdm_pkg::axi_addr_t   aw_addr_i;
  axi_tcdm_pkg::axi_len_t    aw_len_i;
  axi_tcdm_pkg::axi_id_t     aw_id_i;
  logic                      aw_ready_o;
  logic                      ar_valid_i;
  axi_tcdm_pkg::axi_addr_t   ar_addr_i;
  axi_tcdm_pkg::axi_len_t    ar_len_i;
  axi_tcdm_pkg::axi_id_t     ar_id_i;
  logic                      ar_ready_o;
  logic                      w_valid_i;
  axi_tcdm_pkg::axi_data_t   w_data_i;
  axi_tcdm_pkg::axi_strb_t   w_strb_i;
  logic                      w_last_i;
  logic                      w_ready_o;
  logic                      r_valid_o;
  axi_tcdm_pkg::axi_data_t   r_data_o;
  axi_tcdm_pkg::axi_resp_t   r_resp_o;
  logic                      r_last_o;
  axi_tcdm_pkg::axi_id_t     r_id_o;
  logic                      r_ready_i;
  logic                      b_valid_o;
  axi_tcdm_pkg::axi_resp_t   b_resp_o;
  axi_tcdm_pkg::axi_id_t     b_id_o;
  logic                      b_ready_i;
  logic                      busy_o;

  int         seed = 16217;
  logic [7:0] ref_mem [MEM_BYTES];

  tcdm_subsys_top #(
    .MEM_WORDS ( MEM_WORDS )
  ) i_tcdm_subsys_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    stop_on_error($sformatf("watchdog expired after %0d cycles", WDOG_CYCLES));
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic logic coin();
    logic [31:0] r;
    r = rand_word();
    return r[0];
  endfunction

  // byte i of a beat lives at beat address + i, lane 1 holds the upper word
  function automatic axi_tcdm_pkg::axi_data_t model_beat(input int addr);
    axi_tcdm_pkg::axi_data_t d;
    for (int i = 0; i < 8; i++) begin
      d[8*i +: 8] = ref_mem[addr + i];
    end
    return d;
  endfunction

  function automatic void write_model(input int addr, input axi_tcdm_pkg::axi_data_t data,
                                      input axi_tcdm_pkg::axi_strb_t strb);
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        ref_mem[addr + i] = data[8*i +: 8];
      end
    end
  endfunction

  task automatic axi_write(input int base, input int nbeats, input axi_tcdm_pkg::axi_id_t id,
                           input logic rand_strb);
    axi_tcdm_pkg::axi_data_t data;
    axi_tcdm_pkg::axi_strb_t strb;
    int   gap;
    logic waiting;
    logic done;
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    aw_addr_i  = axi_tcdm_pkg::axi_addr_t'(base);
    aw_len_i   = axi_tcdm_pkg::axi_len_t'(nbeats - 1);
    aw_id_i    = id;
    do begin
      @(posedge clk_i);
      check("busy_o", 64'(busy_o), 64'd0);
    end while (!aw_ready_o);
    for (int b = 0; b < nbeats; b++) begin
      @(negedge clk_i);
      aw_valid_i = 1'b0;
      w_valid_i  = 1'b0;
      gap = int'(rand_word() % 3);
      repeat (gap) @(negedge clk_i);
      data = {rand_word(), rand_word()};
      strb = rand_strb ? axi_tcdm_pkg::axi_strb_t'(rand_word()) : '1;
      w_valid_i = 1'b1;
      w_data_i  = data;
      w_strb_i  = strb;
      w_last_i  = (b == nbeats - 1);
      do begin
        @(posedge clk_i);
        check("busy_o", 64'(busy_o), 64'd1);
      end while (!w_ready_o);
      write_model(base + 8 * b, data, strb);
    end
    @(negedge clk_i);
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    b_ready_i = coin();
    waiting   = 1'b0;
    done      = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      check("busy_o", 64'(busy_o), 64'd1);
      if (b_valid_o) begin
        check("b_id_o", 64'(b_id_o), 64'(id));
        // every response is OKAY, which AXI encodes as zero
        check("b_resp_o", 64'(b_resp_o), 64'd0);
        done    = b_ready_i;
        waiting = !b_ready_i;
      end else if (waiting) begin
        stop_on_error("b_valid_o dropped while b_ready_i was still low");
      end
      @(negedge clk_i);
      b_ready_i = done ? 1'b0 : coin();
    end
    @(posedge clk_i);
    check("busy_o", 64'(busy_o), 64'd0);
  endtask

  task automatic axi_read(input int base, input int nbeats, input axi_tcdm_pkg::axi_id_t id);
    int   beat;
    logic waiting;
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_addr_i  = axi_tcdm_pkg::axi_addr_t'(base);
    ar_len_i   = axi_tcdm_pkg::axi_len_t'(nbeats - 1);
    ar_id_i    = id;
    do begin
      @(posedge clk_i);
      check("busy_o", 64'(busy_o), 64'd0);
    end while (!ar_ready_o);
    beat    = 0;
    waiting = 1'b0;
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    r_ready_i  = coin();
    while (beat < nbeats) begin
      @(posedge clk_i);
      check("busy_o", 64'(busy_o), 64'd1);
      if (r_valid_o) begin
        // compared every valid cycle, so a stalled beat must also hold still
        check("r_data_o", r_data_o, model_beat(base + 8 * beat));
        check("r_last_o", 64'(r_last_o), (beat == nbeats - 1) ? 64'd1 : 64'd0);
        check("r_id_o", 64'(r_id_o), 64'(id));
        check("r_resp_o", 64'(r_resp_o), 64'd0);
        waiting = !r_ready_i;
        if (r_ready_i) begin
          beat++;
        end
      end else if (waiting) begin
        stop_on_error("r_valid_o dropped while r_ready_i was still low");
      end
      @(negedge clk_i);
      r_ready_i = (beat < nbeats) ? coin() : 1'b0;
    end
    @(posedge clk_i);
    check("busy_o", 64'(busy_o), 64'd0);
  endtask

  initial begin : main
    int nbeats;
    int base;
    int op;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_id_i    = '0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_id_i    = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    r_ready_i  = 1'b0;
    b_ready_i  = 1'b0;
    arst_n_i   = 1'b0;
    repeat (5) @(negedge clk_i);
    arst_n_i = 1'b1;

    @(posedge clk_i);
    check("aw_ready_o", 64'(aw_ready_o), 64'd1);
    check("ar_ready_o", 64'(ar_ready_o), 64'd1);
    check("w_ready_o", 64'(w_ready_o), 64'd0);
    check("r_valid_o", 64'(r_valid_o), 64'd0);
    check("b_valid_o", 64'(b_valid_o), 64'd0);
    check("busy_o", 64'(busy_o), 64'd0);

    // the SRAM starts undefined, so every byte is written once first
    for (int k = 0; k < NUM_FILL; k++) begin
      axi_write(k * 128, 16, axi_tcdm_pkg::axi_id_t'(rand_word()), 1'b0);
    end

    for (int n = 0; n < NUM_RAND; n++) begin
      nbeats = int'(rand_word() % 16) + 1;
      base   = int'(rand_word() % (MEM_BEATS - nbeats + 1)) * 8;
      op     = int'(rand_word() % 3);
      case (op)
        0: begin
          axi_write(base, nbeats, axi_tcdm_pkg::axi_id_t'(rand_word()), 1'b0);
          axi_read(base, nbeats, axi_tcdm_pkg::axi_id_t'(rand_word()));
        end
        1: axi_write(base, nbeats, axi_tcdm_pkg::axi_id_t'(rand_word()), 1'b1);
        default: axi_read(base, nbeats, axi_tcdm_pkg::axi_id_t'(rand_word()));
      endcase
    end

    // whole memory against the model once more
    for (int k = 0; k < NUM_FILL; k++) begin
      axi_read(k * 128, 16, axi_tcdm_pkg::axi_id_t'(rand_word()));
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: flist.f
rtl/axi_tcdm_pkg.sv
rtl/tcdm_if.sv
rtl/axi2mem.sv
rtl/axi2mem_wrap.sv
rtl/tcdm_rr_arbiter.sv
rtl/tcdm_sram.sv
rtl/tcdm_subsys_top.sv
testbench/tb_tcdm_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the AXI to TCDM subsystem testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass line.
set -euo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_tcdm_subsys \
  -o Vtb_tcdm_subsys

./obj_dir/Vtb_tcdm_subsys 2>&1 | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
